// File: tape_mmio.f
+incdir+hdl
hdl/tape_pkg.sv
hdl/tape_regs.sv
hdl/tape_sample_ram.sv
hdl/tape_player.sv
hdl/tape_bit_decoder.sv
hdl/tape_byte_fifo.sv
hdl/tape_mmio.sv
testbench/tape_mmio_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the tape_mmio testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   -f tape_mmio.f --top-module tape_mmio_tb -o tape_sim

output="$(./obj_dir/tape_sim)"
echo "$output"

if grep -q "Simulation finished: PASS" <<< "$output"; then
   exit 0
else
   exit 1
fi

// File: testbench/tape_mmio_tb.sv
`include "tape_config.svh"
`timescale 1ns/1ps
`default_nettype none

module tape_mmio_tb;

   import tape_pkg::*;

   localparam logic [13:0] ctrl_addr    = 14'h2000;
   localparam logic [13:0] ptrs_addr    = 14'h2004;
   localparam logic [13:0] memsize_addr = 14'h2008;
   localparam logic [13:0] tape_addr    = 14'h200c;
   localparam rate_t       play_rate    = 11'd2;
   localparam int          timeout_cycles = 60000;

   logic        clk;
   logic        reset;
   apb_req_t    apb_req;
   apb_rsp_t    apb_rsp;
   logic        tick_en;
   logic        motor_on;
   logic        tape_sense;
   logic        tape_in;
   sample_t     tape_audio;
   logic        audio_strobe;

   int          errors = 0;
   int          cycles = 0;
   int          tick_phase;
   int          tick_count = 0;
   int          last_strobe;
   int          strobe_gap;
   logic        strobe_ok;
   logic        first_strobe;
   logic        expect_silent;
   logic        exp_ovf;
   sample_t     exp_samples[$];
   tape_byte_t  exp_bytes[$];
   sample_t     exp_sample;
   tape_byte_t  exp_byte;
   tape_byte_t  tx_byte;
   word_t       tape_word;
   word_t       rd_data;
   logic        rd_err;

   tape_mmio tape_mmio_inst (
      .clk, .reset, .apb_req, .apb_rsp, .tick_en, .motor_on,
      .tape_sense, .tape_in, .tape_audio, .audio_strobe
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // one tick in every four clocks
   initial begin
      tick_en    = 1'b0;
      tick_phase = 0;
      forever begin
         @(posedge clk);
         #2;
         tick_en    = (tick_phase == 3);
         tick_phase = (tick_phase + 1) % 4;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
         $display("ERROR: run did not finish within %0d cycles", timeout_cycles);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                  input logic [31:0] act_v);
      errors++;
      $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
   endtask

   task automatic expect_eq(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
      assert (act_v === exp_v) else report_mismatch(name, exp_v, act_v);
   endtask

   task automatic apb_write(input logic [13:0] addr, input word_t data,
                            input logic [3:0] strb, output logic err);
      @(posedge clk);
      #2;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = 1'b1;
      apb_req.paddr   = addr;
      apb_req.pwdata  = data;
      apb_req.pstrb   = strb;
      @(posedge clk);
      #2;
      apb_req.penable = 1'b1;
      @(negedge clk);
      err = apb_rsp.pslverr;
      @(posedge clk);
      #2;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [13:0] addr, output word_t data, output logic err);
      @(posedge clk);
      #2;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = 1'b0;
      apb_req.paddr   = addr;
      @(posedge clk);
      #2;
      apb_req.penable = 1'b1;
      @(negedge clk);
      data = apb_rsp.prdata;
      err  = apb_rsp.pslverr;
      @(posedge clk);
      #2;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
   endtask

   function automatic word_t ctrl_word(input fmt_t f, input logic play_bit);
      return {5'd0, play_rate, 13'd0, f, play_bit};
   endfunction

   // 8-bit code to 16-bit sample with the top bit flipped
   function automatic sample_t mono8_sample(input logic [7:0] b);
      return sample_t'({b ^ 8'h80, b});
   endfunction

   function automatic sample_t stereo16_sample(input logic [15:0] l, input logic [15:0] r);
      int sum;
      sum = int'($signed(l)) + int'($signed(r));
      return sample_t'(sum >>> 1);
   endfunction

   task automatic queue_word(input fmt_t f, input word_t w);
      logic [8:0] sum_lo;
      logic [8:0] sum_hi;
      sum_lo = 9'(w[7:0]) + 9'(w[15:8]);
      sum_hi = 9'(w[23:16]) + 9'(w[31:24]);
      case (f)
         fmt_mono8: begin
            for (int i = 0; i < 4; i++) begin
               exp_samples.push_back(mono8_sample(w[8*i +: 8]));   // byte 0 first
            end
         end
         fmt_mono16: begin
            exp_samples.push_back(sample_t'(w[15:0]));
            exp_samples.push_back(sample_t'(w[31:16]));
         end
         fmt_stereo8: begin
            exp_samples.push_back(mono8_sample(sum_lo[8:1]));
            exp_samples.push_back(mono8_sample(sum_hi[8:1]));
         end
         default: exp_samples.push_back(stereo16_sample(w[15:0], w[31:16]));
      endcase
   endtask

   task automatic load_words(input fmt_t f, input int nwords);
      word_t w;
      apb_write(ctrl_addr, ctrl_word(f, 1'b0), 4'hf, rd_err);
      for (int i = 0; i < nwords; i++) begin
         w = $urandom;
         apb_write(14'(4 * i), w, 4'hf, rd_err);
         queue_word(f, w);
      end
      apb_write(ptrs_addr, {5'd0, 11'(nwords), 5'd0, 11'd0}, 4'hf, rd_err);
   endtask

   task automatic wait_samples();
      while (exp_samples.size() != 0) @(posedge clk);
   endtask

   task automatic run_format(input fmt_t f, input int nwords);
      load_words(f, nwords);
      first_strobe = 1'b1;
      strobe_ok    = 1'b1;
      apb_write(ctrl_addr, ctrl_word(f, 1'b1), 4'hf, rd_err);
      wait_samples();
      repeat (40) @(posedge clk);   // any extra strobe shows up here
      apb_read(ptrs_addr, rd_data, rd_err);
      expect_eq("head", 32'(nwords), 32'(rd_data[10:0]));
      strobe_ok = 1'b0;
      apb_write(ctrl_addr, ctrl_word(f, 1'b0), 4'hf, rd_err);
   endtask

   task automatic tape_interval(input int n);
      repeat (n) @(posedge tick_en);
      tape_in = ~tape_in;
   endtask

   task automatic send_bit(input logic b);
      if (b) begin
         tape_interval(16);
         tape_interval(16);
      end else begin
         tape_interval(32);
      end
   endtask

   task automatic send_byte(input tape_byte_t b, input logic expected);
      for (int i = 7; i >= 0; i--) begin
         send_bit(b[i]);
      end
      if (expected) begin
         if (exp_bytes.size() < `TAPE_FIFO_DEPTH) begin
            exp_bytes.push_back(b);
         end else begin
            exp_ovf = 1'b1;   // fifo full so the byte is lost
         end
      end
   endtask

   task automatic send_preamble();
      tape_interval(`TAPE_TIMEOUT + 12);   // lead edge after idle
      repeat (`TAPE_SYNC_ZEROS) send_bit(1'b0);
      send_bit(1'b1);
   endtask

   always @(negedge clk) begin
      if (!reset) begin
         if (tick_en) begin
            tick_count++;
         end
         if (apb_req.psel && apb_req.penable) begin
            assert (apb_rsp.pready === 1'b1)
               else report_mismatch("pready", 32'd1, 32'(apb_rsp.pready));
         end
         if (audio_strobe) begin
            assert (strobe_ok && exp_samples.size() != 0) else begin
               errors++;
               $display("ERROR at %0t ns: audio strobe while none expected", $time);
            end
            if (exp_samples.size() != 0) begin
               exp_sample = exp_samples.pop_front();
               assert (tape_audio == exp_sample)
                  else report_mismatch("tape_audio", 32'(exp_sample), 32'(tape_audio));
               if (!first_strobe) begin
                  assert (tick_count - last_strobe == strobe_gap)
                     else report_mismatch("strobe spacing in ticks", 32'(strobe_gap),
                                          32'(tick_count - last_strobe));
               end
               first_strobe = 1'b0;
               last_strobe  = tick_count;
            end
         end
         if (expect_silent) begin
            assert (tape_audio == 16'sd0) else report_mismatch("tape_audio", 32'd0,
                                                              32'(tape_audio));
         end
         if (apb_req.psel && apb_req.penable && !apb_req.pwrite &&
             apb_req.paddr == tape_addr) begin
            tape_word = apb_rsp.prdata;
            assert (tape_word[10] == motor_on)
               else report_mismatch("tape motor_on bit", 32'(motor_on), 32'(tape_word[10]));
            assert (tape_word[11] == tape_sense)
               else report_mismatch("tape sense bit", 32'(tape_sense), 32'(tape_word[11]));
            assert (tape_word[9] == exp_ovf)
               else report_mismatch("tape overflow bit", 32'(exp_ovf), 32'(tape_word[9]));
            if (exp_bytes.size() != 0) begin
               exp_byte = exp_bytes.pop_front();
               assert (tape_word[8:0] == {1'b1, exp_byte})
                  else report_mismatch("tape byte", {23'd0, 1'b1, exp_byte},
                                       32'(tape_word[8:0]));
               exp_ovf = 1'b0;   // pop clears the flag
            end else begin
               assert (tape_word[8] == 1'b0)
                  else report_mismatch("tape valid bit", 32'd0, 32'(tape_word[8]));
            end
         end
      end
   end

   initial begin
      void'($urandom(24406));
      reset         = 1'b1;
      apb_req       = '0;
      motor_on      = 1'b0;
      tape_sense    = 1'b0;
      tape_in       = 1'b0;
      strobe_ok     = 1'b0;
      first_strobe  = 1'b1;
      expect_silent = 1'b1;
      exp_ovf       = 1'b0;
      strobe_gap    = int'(play_rate) + 1;
      repeat (3) @(posedge clk);
      #2;
      reset = 1'b0;

      // registers after reset, readback and error responses
      apb_read(ctrl_addr, rd_data, rd_err);
      expect_eq("ctrl", 32'd0, rd_data);
      apb_read(ptrs_addr, rd_data, rd_err);
      expect_eq("ptrs", 32'd0, rd_data);
      apb_read(memsize_addr, rd_data, rd_err);
      expect_eq("memsize", `TAPE_MEM_BYTES, rd_data);
      apb_read(tape_addr, rd_data, rd_err);
      apb_write(ctrl_addr, 32'hffff_ffff, 4'hf, rd_err);
      expect_eq("ctrl write pslverr", 32'd0, 32'(rd_err));
      apb_read(ctrl_addr, rd_data, rd_err);
      expect_eq("ctrl", 32'h07ff_0007, rd_data);
      apb_write(ctrl_addr, 32'd0, 4'hf, rd_err);
      apb_write(ptrs_addr, 32'habcd_1234, 4'hf, rd_err);
      apb_read(ptrs_addr, rd_data, rd_err);
      expect_eq("ptrs", 32'h03cd_0234, rd_data);
      apb_write(ptrs_addr, 32'd0, 4'hf, rd_err);
      apb_write(memsize_addr, 32'h0000_1234, 4'hf, rd_err);
      expect_eq("memsize write pslverr", 32'd1, 32'(rd_err));
      apb_read(memsize_addr, rd_data, rd_err);
      expect_eq("memsize", `TAPE_MEM_BYTES, rd_data);
      apb_write(tape_addr, 32'h0000_00ff, 4'hf, rd_err);
      expect_eq("tape write pslverr", 32'd1, 32'(rd_err));
      apb_read(14'h0010, rd_data, rd_err);
      expect_eq("memory read pslverr", 32'd1, 32'(rd_err));
      expect_eq("memory read prdata", 32'd0, rd_data);
      apb_write(14'h0000, 32'h1234_5678, 4'hf, rd_err);
      expect_eq("memory write pslverr", 32'd0, 32'(rd_err));
      expect_silent = 1'b0;

      // playback in all four formats
      motor_on = 1'b1;
      run_format(fmt_mono8, 3);
      run_format(fmt_mono16, 3);
      run_format(fmt_stereo8, 3);
      run_format(fmt_stereo16, 3);

      // motor and play gating
      load_words(fmt_mono16, 3);
      first_strobe = 1'b1;
      strobe_ok    = 1'b1;
      apb_write(ctrl_addr, ctrl_word(fmt_mono16, 1'b1), 4'hf, rd_err);
      while (exp_samples.size() > 4) @(posedge clk);
      #2;
      motor_on  = 1'b0;
      strobe_ok = 1'b0;
      repeat (2) @(posedge clk);
      expect_silent = 1'b1;
      repeat (60) @(posedge clk);
      expect_silent = 1'b0;
      first_strobe  = 1'b1;
      strobe_ok     = 1'b1;
      #2;
      motor_on = 1'b1;
      wait_samples();
      repeat (8) @(posedge clk);
      strobe_ok = 1'b0;
      apb_write(ctrl_addr, ctrl_word(fmt_mono16, 1'b0), 4'hf, rd_err);
      @(posedge clk);   // output clears one clock after play drops
      expect_silent = 1'b1;
      repeat (40) @(posedge clk);
      expect_silent = 1'b0;
      apb_read(ptrs_addr, rd_data, rd_err);
      expect_eq("head", 32'd3, 32'(rd_data[10:0]));

      // tape decoding
      motor_on   = 1'b0;
      tape_sense = 1'b1;
      send_preamble();
      for (int i = 0; i < 4; i++) begin
         tx_byte = tape_byte_t'($urandom);
         send_byte(tx_byte, 1'b1);
      end
      repeat (8) @(posedge clk);
      for (int i = 0; i < 5; i++) begin
         apb_read(tape_addr, rd_data, rd_err);
         motor_on   = ~motor_on;
         tape_sense = (i % 2 == 0);
      end

      // overflow with no reads
      send_preamble();
      for (int i = 0; i < 10; i++) begin
         tx_byte = tape_byte_t'($urandom);
         send_byte(tx_byte, 1'b1);
      end
      repeat (8) @(posedge clk);
      for (int i = 0; i < 9; i++) begin
         apb_read(tape_addr, rd_data, rd_err);
      end

      // sync loss after a bad interval
      send_preamble();
      tx_byte = tape_byte_t'($urandom);
      send_byte(tx_byte, 1'b1);
      tape_interval(6);   // fits neither window
      for (int i = 0; i < 2; i++) begin
         tx_byte = tape_byte_t'($urandom);
         send_byte(tx_byte, 1'b0);
      end
      repeat (8) @(posedge clk);
      apb_read(tape_addr, rd_data, rd_err);
      apb_read(tape_addr, rd_data, rd_err);

      repeat (4) @(posedge clk);
      $display("Checks complete, %0d errors", errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: hdl/tape_mmio.sv
`timescale 1ns/1ps
`default_nettype none

module tape_mmio (
   input  wire                clk,
   input  wire                reset,
   input  tape_pkg::apb_req_t apb_req,
   output tape_pkg::apb_rsp_t apb_rsp,
   input  wire                tick_en,
   input  wire                motor_on,
   input  wire                tape_sense,
   input  wire                tape_in,
   output tape_pkg::sample_t  tape_audio,
   output logic               audio_strobe
);

   import tape_pkg::*;

   logic       mem_we;
   ptr_t       mem_addr;
   word_t      mem_wdata;
   logic [3:0] mem_strb;
   logic       play;
   fmt_t       fmt;
   rate_t      sample_rate;
   ptr_t       head;
   ptr_t       tail;
   logic       fetch;
   ptr_t       ram_raddr;
   logic       ram_re;
   word_t      ram_rdata;
   tape_byte_t dec_byte;
   logic       dec_valid;
   tape_byte_t fifo_byte;
   logic       fifo_empty;
   logic       fifo_overflow;
   logic       fifo_pop;

   tape_regs tape_regs_inst (
      .clk, .reset, .apb_req, .apb_rsp,
      .mem_we, .mem_addr, .mem_wdata, .mem_strb,
      .play, .fmt, .sample_rate, .head, .tail, .fetch,
      .fifo_byte, .fifo_empty, .fifo_overflow, .fifo_pop,
      .motor_on, .tape_sense
   );

   tape_sample_ram tape_sample_ram_inst (
      .clk,
      .we    (mem_we),
      .waddr (mem_addr),
      .wdata (mem_wdata),
      .strb  (mem_strb),
      .re    (ram_re),
      .raddr (ram_raddr),
      .rdata (ram_rdata)
   );

   tape_player tape_player_inst (
      .clk, .reset, .tick_en, .play, .motor_on, .fmt, .sample_rate,
      .head, .tail, .fetch, .ram_raddr, .ram_re, .ram_rdata,
      .tape_audio, .audio_strobe
   );

   tape_bit_decoder tape_bit_decoder_inst (
      .clk, .reset, .tick_en, .tape_in,
      .byte_out   (dec_byte),
      .byte_valid (dec_valid)
   );

   tape_byte_fifo tape_byte_fifo_inst (
      .clk, .reset,
      .push     (dec_valid),
      .din      (dec_byte),
      .pop      (fifo_pop),
      .dout     (fifo_byte),
      .empty    (fifo_empty),
      .overflow (fifo_overflow)
   );

endmodule

`default_nettype wire

// File: hdl/tape_byte_fifo.sv
`include "tape_config.svh"
`timescale 1ns/1ps
`default_nettype none

module tape_byte_fifo (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  push,
   input  tape_pkg::tape_byte_t din,
   input  wire                  pop,
   output tape_pkg::tape_byte_t dout,
   output logic                 empty,
   output logic                 overflow
);

   import tape_pkg::*;

   tape_byte_t                           mem [`TAPE_FIFO_DEPTH];
   logic [$clog2(`TAPE_FIFO_DEPTH)-1:0] wr_ptr;
   logic [$clog2(`TAPE_FIFO_DEPTH)-1:0] rd_ptr;
   logic [$clog2(`TAPE_FIFO_DEPTH):0]   count;
   logic                                full;
   logic                                do_push;
   logic                                do_pop;

   assign full    = (count == `TAPE_FIFO_DEPTH);
   assign empty   = (count == '0);
   assign do_pop  = pop & ~empty;
   assign do_push = push & (~full | do_pop);   // a pop frees the slot
   assign dout    = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
         if (do_pop) begin
            overflow <= 1'b0;
         end else if (push && full) begin
            overflow <= 1'b1;   // byte dropped
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/tape_bit_decoder.sv
`include "tape_config.svh"
`timescale 1ns/1ps
`default_nettype none

module tape_bit_decoder (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  tick_en,
   input  wire                  tape_in,
   output tape_pkg::tape_byte_t byte_out,
   output logic                 byte_valid
);

   import tape_pkg::*;

   dec_state_t state;
   logic       tape_last;
   logic       tape_edge;
   logic [5:0] ival_cnt;   // ticks since last edge
   logic [5:0] ival_len;
   logic       is_short;
   logic       is_long;
   logic       half_one;   // first short of a 1 seen
   logic       timeout;
   logic       bit_valid;
   logic       bit_val;
   logic       bad_ival;
   logic [4:0] zero_cnt;
   logic [2:0] bit_cnt;
   tape_byte_t shreg;

   assign tape_edge = tape_in ^ tape_last;
   assign ival_len  = ival_cnt + 6'd1;
   assign is_short  = (ival_len >= `TAPE_SHORT_MIN) && (ival_len <= `TAPE_SHORT_MAX);
   assign is_long   = (ival_len >= `TAPE_LONG_MIN) && (ival_len <= `TAPE_LONG_MAX);
   assign timeout   = ~tape_edge & (ival_cnt == 6'(`TAPE_TIMEOUT));

   always_comb begin
      bit_valid = 1'b0;
      bit_val   = 1'b0;
      bad_ival  = 1'b0;
      if (tape_edge) begin
         if (is_long) begin
            bit_valid = ~half_one;
            bad_ival  = half_one;   // long after a lone short
         end else if (is_short) begin
            bit_valid = half_one;
            bit_val   = 1'b1;
         end else begin
            bad_ival = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= dec_hunt;
         tape_last  <= 1'b0;
         ival_cnt   <= '0;
         half_one   <= 1'b0;
         zero_cnt   <= '0;
         bit_cnt    <= '0;
         byte_valid <= 1'b0;
      end else begin
         byte_valid <= 1'b0;
         if (tick_en) begin
            tape_last <= tape_in;
            if (tape_edge) begin
               ival_cnt <= '0;
               half_one <= is_short & ~half_one;
            end else if (!timeout) begin
               ival_cnt <= ival_cnt + 6'd1;
            end

            if (bad_ival || timeout) begin
               state    <= dec_hunt;
               zero_cnt <= '0;
               half_one <= 1'b0;
            end else if (bit_valid) begin
               case (state)
                  dec_hunt: begin
                     if (!bit_val) begin
                        state    <= dec_preamble;
                        zero_cnt <= 5'd1;
                     end
                  end
                  dec_preamble: begin
                     if (!bit_val) begin
                        if (zero_cnt != 5'(`TAPE_SYNC_ZEROS)) begin
                           zero_cnt <= zero_cnt + 5'd1;
                        end
                     end else if (zero_cnt == 5'(`TAPE_SYNC_ZEROS)) begin
                        state   <= dec_data;   // sync bit
                        bit_cnt <= '0;
                     end else begin
                        state    <= dec_hunt;
                        zero_cnt <= '0;
                     end
                  end
                  default: begin
                     shreg   <= {shreg[6:0], bit_val};   // msb first
                     bit_cnt <= bit_cnt + 3'd1;
                     if (bit_cnt == 3'd7) begin
                        byte_out   <= {shreg[6:0], bit_val};
                        byte_valid <= 1'b1;
                     end
                  end
               endcase
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/tape_player.sv
`timescale 1ns/1ps
`default_nettype none

module tape_player (
   input  wire               clk,
   input  wire               reset,
   input  wire               tick_en,
   input  wire               play,
   input  wire               motor_on,
   input  tape_pkg::fmt_t    fmt,
   input  tape_pkg::rate_t   sample_rate,
   input  tape_pkg::ptr_t    head,
   input  tape_pkg::ptr_t    tail,
   output logic              fetch,
   output tape_pkg::ptr_t    ram_raddr,
   output logic              ram_re,
   input  tape_pkg::word_t   ram_rdata,
   output tape_pkg::sample_t tape_audio,
   output logic              audio_strobe
);

   import tape_pkg::*;

   logic        active;
   logic        data_valid;
   logic        fetch_pending;   // ram word lands next cycle
   word_t       shreg;
   logic [2:0]  remaining;
   rate_t       rate_cnt;
   logic [8:0]  mix8;
   logic [16:0] mix16;
   logic [7:0]  m8;
   sample_t     next_sample;

   function automatic logic [2:0] samples_per_word(input fmt_t f);
      case (f)
         fmt_mono8:   return 3'd4;
         fmt_mono16:  return 3'd2;
         fmt_stereo8: return 3'd2;
         default:     return 3'd1;
      endcase
   endfunction

   assign active    = play & motor_on;
   assign fetch     = play & ~data_valid & ~fetch_pending & (head != tail);
   assign ram_re    = fetch;
   assign ram_raddr = head;

   assign mix8  = {1'b0, shreg[7:0]} + {1'b0, shreg[15:8]};
   assign mix16 = {shreg[15], shreg[15:0]} + {shreg[31], shreg[31:16]};
   assign m8    = mix8[8:1];

   always_comb begin
      case (fmt)
         fmt_mono8:   next_sample = {~shreg[7], shreg[6:0], shreg[7:0]};
         fmt_mono16:  next_sample = shreg[15:0];
         fmt_stereo8: next_sample = {~m8[7], m8[6:0], m8};
         default:     next_sample = mix16[16:1];
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         data_valid    <= 1'b0;
         fetch_pending <= 1'b0;
         remaining     <= '0;
         rate_cnt      <= '0;
         tape_audio    <= '0;
         audio_strobe  <= 1'b0;
      end else begin
         audio_strobe  <= 1'b0;
         fetch_pending <= fetch;

         if (!play) begin
            data_valid <= 1'b0;   // drop held word
            remaining  <= '0;
         end else if (fetch_pending) begin
            shreg      <= ram_rdata;
            data_valid <= 1'b1;
            remaining  <= samples_per_word(fmt);
         end

         if (!active) begin
            tape_audio <= '0;
            rate_cnt   <= '0;
         end else if (tick_en) begin
            if (rate_cnt != '0) begin
               rate_cnt <= rate_cnt - 1'b1;
            end else begin
               rate_cnt <= sample_rate;
               if (data_valid) begin
                  tape_audio   <= next_sample;
                  audio_strobe <= 1'b1;
                  shreg        <= (fmt == fmt_mono8) ? (shreg >> 8) : (shreg >> 16);
                  remaining    <= remaining - 3'd1;
                  if (remaining == 3'd1) begin
                     data_valid <= 1'b0;
                  end
               end
               // otherwise underrun, output holds
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/tape_sample_ram.sv
`include "tape_config.svh"
`timescale 1ns/1ps
`default_nettype none

module tape_sample_ram (
   input  wire             clk,
   input  wire             we,
   input  tape_pkg::ptr_t  waddr,
   input  tape_pkg::word_t wdata,
   input  wire [3:0]       strb,
   input  wire             re,
   input  tape_pkg::ptr_t  raddr,
   output tape_pkg::word_t rdata
);

   // one array per byte lane, lane 0 is the first byte played
   for (genvar lane = 0; lane < 4; lane++) begin : g_lane
      logic [7:0] mem [`TAPE_MEM_WORDS];
      logic [7:0] rd_byte;

      always_ff @(posedge clk) begin
         if (we && strb[lane]) begin
            mem[waddr] <= wdata[8*lane +: 8];
         end
         if (re) begin
            rd_byte <= mem[raddr];
         end
      end

      assign rdata[8*lane +: 8] = rd_byte;
   end

endmodule

`default_nettype wire

// File: hdl/tape_regs.sv
`include "tape_config.svh"
`timescale 1ns/1ps
`default_nettype none

module tape_regs (
   input  wire                 clk,
   input  wire                 reset,
   input  tape_pkg::apb_req_t  apb_req,
   output tape_pkg::apb_rsp_t  apb_rsp,
   output logic                mem_we,
   output tape_pkg::ptr_t      mem_addr,
   output tape_pkg::word_t     mem_wdata,
   output logic [3:0]          mem_strb,
   output logic                play,
   output tape_pkg::fmt_t      fmt,
   output tape_pkg::rate_t     sample_rate,
   output tape_pkg::ptr_t      head,
   output tape_pkg::ptr_t      tail,
   input  wire                 fetch,
   input  tape_pkg::tape_byte_t fifo_byte,
   input  wire                 fifo_empty,
   input  wire                 fifo_overflow,
   output logic                fifo_pop,
   input  wire                 motor_on,
   input  wire                 tape_sense
);

   import tape_pkg::*;

   localparam reg_idx_t reg_ctrl    = 3'd0;
   localparam reg_idx_t reg_ptrs    = 3'd1;
   localparam reg_idx_t reg_memsize = 3'd2;
   localparam reg_idx_t reg_tape    = 3'd3;

   logic     access;
   logic     reg_sel;
   logic     wr_en;
   logic     rd_en;
   reg_idx_t idx;
   word_t    rd_mux;

   assign access  = apb_req.psel & apb_req.penable;
   assign reg_sel = apb_req.paddr[13];   // clear selects sample memory
   assign idx     = apb_req.paddr[4:2];
   assign wr_en   = access & apb_req.pwrite;
   assign rd_en   = access & ~apb_req.pwrite;

   assign mem_we    = wr_en & ~reg_sel;
   assign mem_addr  = apb_req.paddr[12:2];
   assign mem_wdata = apb_req.pwdata;
   assign mem_strb  = apb_req.pstrb;

   assign fifo_pop = rd_en & reg_sel & (idx == reg_tape) & ~fifo_empty;

   always_comb begin
      case (idx)
         reg_ctrl:    rd_mux = {5'd0, sample_rate, 13'd0, fmt, play};
         reg_ptrs:    rd_mux = {5'd0, tail, 5'd0, head};
         reg_memsize: rd_mux = word_t'(`TAPE_MEM_BYTES);
         reg_tape:    rd_mux = {20'd0, tape_sense, motor_on, fifo_overflow,
                                ~fifo_empty, fifo_byte};
         default:     rd_mux = '0;
      endcase
   end

   assign apb_rsp.prdata  = reg_sel ? rd_mux : '0;   // memory is write-only
   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = (rd_en & ~reg_sel) |
                            (wr_en & reg_sel & (idx >= reg_memsize));

   always_ff @(posedge clk) begin
      if (reset) begin
         play        <= 1'b0;
         fmt         <= fmt_mono8;
         sample_rate <= '0;
         head        <= '0;
         tail        <= '0;
      end else begin
         if (wr_en && reg_sel && idx == reg_ctrl) begin
            play        <= apb_req.pwdata[0];
            fmt         <= fmt_t'(apb_req.pwdata[2:1]);
            sample_rate <= apb_req.pwdata[26:16];
         end
         if (wr_en && reg_sel && idx == reg_ptrs) begin
            head <= apb_req.pwdata[10:0];   // bus write wins over fetch
            tail <= apb_req.pwdata[26:16];
         end else if (fetch) begin
            head <= head + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/tape_pkg.sv
`include "tape_config.svh"
`default_nettype none

package tape_pkg;

   typedef logic [31:0] word_t;
   typedef logic signed [15:0] sample_t;
   typedef logic [`TAPE_PTR_BITS-1:0] ptr_t;
   typedef logic [10:0] rate_t;
   typedef logic [7:0] tape_byte_t;
   typedef logic [2:0] reg_idx_t;

   typedef enum logic [1:0] {
      fmt_mono8    = 2'd0,
      fmt_mono16   = 2'd1,
      fmt_stereo8  = 2'd2,
      fmt_stereo16 = 2'd3
   } fmt_t;

   typedef enum logic [1:0] {
      dec_hunt     = 2'd0,
      dec_preamble = 2'd1,
      dec_data     = 2'd2
   } dec_state_t;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [13:0] paddr;
      word_t       pwdata;
      logic [3:0]  pstrb;
   } apb_req_t;

   typedef struct packed {
      word_t prdata;
      logic  pready;
      logic  pslverr;
   } apb_rsp_t;

endpackage

`default_nettype wire

// File: hdl/tape_config.svh
`ifndef TAPE_CONFIG_SVH
`define TAPE_CONFIG_SVH

`default_nettype none

// sample memory
`define TAPE_MEM_BYTES 8192
`define TAPE_MEM_WORDS 2048
`define TAPE_PTR_BITS 11

`define TAPE_FIFO_DEPTH 8

// decoder windows in tick units
`define TAPE_SHORT_MIN 12
`define TAPE_SHORT_MAX 20
`define TAPE_LONG_MIN 24
`define TAPE_LONG_MAX 40
`define TAPE_TIMEOUT 48
`define TAPE_SYNC_ZEROS 16

`default_nettype wire

`endif
